/* Makefile */
# Verilator build and run of the ualink turbo64 testbench

VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = tb_ualink_turbo64
FILELIST  = build.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)
LOG       = sim.log
PASS_TEXT = SIMULATION PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, then search $(LOG) for the pass line"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(SIM) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "test: passed"; \
	else \
		echo "test: failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* build.f */
src/ualink_pkg.sv
src/stream_fifo.sv
src/payload_ram.sv
src/command_engine.sv
src/ualink_turbo64.sv
tests/ualink_checker.sv
tests/tb_ualink_turbo64.sv

/* src/command_engine.sv */
/*
 * command engine
 * follows the beat position at the fifo head, decodes read and write
 * commands, drives the payload memory and substitutes read data
 */
`timescale 1ns/100ps

module command_engine
   import ualink_pkg::*;
(
   input  logic      axi_aclk,
   input  logic      axi_resetn,
   input  logic      pop,
   input  word_t     head_data,
   input  logic      head_last,
   input  word_t     rd_data,
   output word_t     out_data,
   output logic      wr_en,
   output ram_addr_t wr_addr,
   output word_t     wr_data,
   output ram_addr_t rd_addr
);

   localparam beat_idx_t last_data_beat = beat_idx_t'(first_data_beat + data_beats - 1);
   localparam beat_idx_t beat_sat       = last_data_beat + beat_idx_t'(1);

   beat_idx_t beat_cnt;   // position of the head beat
   beat_idx_t beat_nxt;   // position after this cycle
   cmd_mode_t mode;
   cmd_mode_t mode_dec;
   ram_addr_t base_addr;
   ram_addr_t base_nxt;

   opcode_t   head_opcode;
   ram_addr_t head_addr;
   logic      in_data;     // head is one of D0..D7
   beat_idx_t wr_offset;
   beat_idx_t rd_offset;

   assign head_opcode = head_data[63:48];
   assign head_addr   = head_data[63:56];

   assign in_data = (beat_cnt >= first_data_beat) && (beat_cnt <= last_data_beat);

   // opcode decode
   always_comb begin
      case (head_opcode)
         op_write: mode_dec = mode_write;
         op_read:  mode_dec = mode_read;
         default:  mode_dec = mode_pass;
      endcase
   end

   // next beat position and base address, as seen after this edge
   always_comb begin
      beat_nxt = beat_cnt;
      base_nxt = base_addr;
      if (pop) begin
         if (head_last)
            beat_nxt = '0;                          // next packet starts over
         else if (beat_cnt != beat_sat)
            beat_nxt = beat_cnt + beat_idx_t'(1);
         if (beat_cnt == addr_beat)
            base_nxt = head_addr;
      end
   end

   // beat counter, mode and base address
   always_ff @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         beat_cnt  <= '0;
         mode      <= mode_pass;
         base_addr <= '0;
      end else begin
         beat_cnt  <= beat_nxt;
         base_addr <= base_nxt;
         if (pop) begin
            if (head_last)
               mode <= mode_pass;                   // command ends with the packet
            else if (beat_cnt == opcode_beat)
               mode <= mode_dec;
         end
      end
   end

   // write path, one word per popped data beat
   assign wr_offset = beat_cnt - first_data_beat;
   assign wr_en     = pop && (mode == mode_write) && in_data;
   assign wr_addr   = base_addr + ram_addr_t'(wr_offset[2:0]); // wraps at 255
   assign wr_data   = head_data;

   // read path
   // address for the beat that will be at the head after this edge,
   // so the registered word lines up with it
   assign rd_offset = beat_nxt - first_data_beat;
   assign rd_addr   = base_nxt + ram_addr_t'(rd_offset[2:0]);

   // output data, memory words replace D0..D7 of a read
   assign out_data = ((mode == mode_read) && in_data) ? rd_data : head_data;

endmodule

/* src/payload_ram.sv */
/*
 * payload memory, 256 x 64
 * one write port and one registered read port
 */
`timescale 1ns/100ps

module payload_ram
   import ualink_pkg::*;
(
   input  logic      axi_aclk,
   input  logic      wr_en,
   input  ram_addr_t wr_addr,
   input  word_t     wr_data,
   input  ram_addr_t rd_addr,
   output word_t     rd_data
);

   localparam int ram_depth = 1 << $bits(ram_addr_t);

   word_t mem [ram_depth]; // undefined until written

   // write port
   always_ff @(posedge axi_aclk) begin
      if (wr_en)
         mem[wr_addr] <= wr_data;
   end

   // read port, one cycle latency
   // re-reads every cycle so the word follows rd_addr while it is held
   always_ff @(posedge axi_aclk) begin
      rd_data <= mem[rd_addr];
   end

endmodule

/* src/stream_fifo.sv */
/*
 * stream fifo, fall-through
 * holds whole axi-stream beats, head visible without a read strobe
 */
`timescale 1ns/100ps

module stream_fifo
   import ualink_pkg::*;
#(
   parameter int fifo_depth_bits = 4
) (
   input  logic  axi_aclk,
   input  logic  axi_resetn,
   input  logic  wr_en,
   input  word_t din_data,
   input  strb_t din_strb,
   input  user_t din_user,
   input  logic  din_last,
   input  logic  rd_en,
   output word_t head_data,
   output strb_t head_strb,
   output user_t head_user,
   output logic  head_last,
   output logic  empty,
   output logic  nearly_full
);

   localparam int depth = 1 << fifo_depth_bits;

   typedef logic [fifo_depth_bits-1:0] ptr_t;
   typedef logic [fifo_depth_bits:0]   cnt_t;

   // beat storage, one entry per beat
   word_t mem_data [depth];
   strb_t mem_strb [depth];
   user_t mem_user [depth];
   logic  mem_last [depth];

   ptr_t wr_ptr;
   ptr_t rd_ptr;
   cnt_t count;

   // storage write
   always_ff @(posedge axi_aclk) begin
      if (wr_en) begin
         mem_data[wr_ptr] <= din_data;
         mem_strb[wr_ptr] <= din_strb;
         mem_user[wr_ptr] <= din_user;
         mem_last[wr_ptr] <= din_last;
      end
   end

   // pointers and occupancy
   always_ff @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (wr_en)
            wr_ptr <= wr_ptr + ptr_t'(1);
         if (rd_en)
            rd_ptr <= rd_ptr + ptr_t'(1);
         case ({wr_en, rd_en})
            2'b10:   count <= count + cnt_t'(1);
            2'b01:   count <= count - cnt_t'(1);
            default: count <= count; // both or neither
         endcase
      end
   end

   // fall-through head
   assign head_data = mem_data[rd_ptr];
   assign head_strb = mem_strb[rd_ptr];
   assign head_user = mem_user[rd_ptr];
   assign head_last = mem_last[rd_ptr];

   assign empty       = (count == '0);
   assign nearly_full = (count >= cnt_t'(depth - 1)); // fewer than two free

endmodule

/* src/ualink_pkg.sv */
/*
 * ualink command endpoint package
 * stream widths, opcodes, beat positions and the command mode type
 */
package ualink_pkg;

   // stream and memory widths
   typedef logic [63:0] word_t;     // data beat, memory word
   typedef logic [7:0]  strb_t;
   typedef logic [31:0] user_t;
   typedef logic [7:0]  ram_addr_t; // 256 payload words
   typedef logic [15:0] opcode_t;
   typedef logic [3:0]  beat_idx_t; // saturates at 12

   // command opcodes, found in beat 1 bits 63..48
   localparam opcode_t op_write = 16'h0245;
   localparam opcode_t op_read  = 16'h0145;

   // packet layout
   // beat 0 = src mac
   // beat 1 = opcode field
   // beat 2 = misc ethernet fields
   // beat 3 = address in bits 63..56
   // beats 4..11 = data words D0..D7
   localparam beat_idx_t opcode_beat     = 4'd1;
   localparam beat_idx_t addr_beat       = 4'd3;
   localparam beat_idx_t first_data_beat = 4'd4;
   localparam integer    data_beats      = 8;

   // what the engine does with the current packet
   typedef enum logic [1:0] {
      mode_pass,
      mode_write,
      mode_read
   } cmd_mode_t;

endpackage

/* src/ualink_turbo64.sv */
/*
 * ualink turbo64 command endpoint, top level
 * input stream -> fifo -> command engine -> output stream, with payload memory
 */
`timescale 1ns/100ps

module ualink_turbo64
   import ualink_pkg::*;
#(
   parameter int fifo_depth_bits = 4
) (
   input  logic  axi_aclk,
   input  logic  axi_resetn,

   // input stream
   input  word_t s_axis_tdata,
   input  strb_t s_axis_tstrb,
   input  user_t s_axis_tuser,
   input  logic  s_axis_tvalid,
   output logic  s_axis_tready,
   input  logic  s_axis_tlast,

   // output stream
   output word_t m_axis_tdata,
   output strb_t m_axis_tstrb,
   output user_t m_axis_tuser,
   output logic  m_axis_tvalid,
   input  logic  m_axis_tready,
   output logic  m_axis_tlast
);

   logic      fifo_wr;
   logic      fifo_empty;
   logic      fifo_nearly_full;
   logic      pop;
   word_t     head_data;
   logic      head_last;

   logic      ram_wr_en;
   ram_addr_t ram_wr_addr;
   word_t     ram_wr_data;
   ram_addr_t ram_rd_addr;
   word_t     ram_rd_data;

   assign s_axis_tready = !fifo_nearly_full;
   assign fifo_wr       = s_axis_tvalid && s_axis_tready;
   assign m_axis_tvalid = !fifo_empty;
   assign pop           = m_axis_tvalid && m_axis_tready; // fifo advances only here
   assign m_axis_tlast  = head_last;

   stream_fifo #(
      .fifo_depth_bits (fifo_depth_bits)
   ) stream_fifo_inst (
      .axi_aclk    (axi_aclk),
      .axi_resetn  (axi_resetn),
      .wr_en       (fifo_wr),
      .din_data    (s_axis_tdata),
      .din_strb    (s_axis_tstrb),
      .din_user    (s_axis_tuser),
      .din_last    (s_axis_tlast),
      .rd_en       (pop),
      .head_data   (head_data),
      .head_strb   (m_axis_tstrb),  // strobes and user pass straight out
      .head_user   (m_axis_tuser),
      .head_last   (head_last),
      .empty       (fifo_empty),
      .nearly_full (fifo_nearly_full)
   );

   command_engine command_engine_inst (
      .axi_aclk   (axi_aclk),
      .axi_resetn (axi_resetn),
      .pop        (pop),
      .head_data  (head_data),
      .head_last  (head_last),
      .rd_data    (ram_rd_data),
      .out_data   (m_axis_tdata),
      .wr_en      (ram_wr_en),
      .wr_addr    (ram_wr_addr),
      .wr_data    (ram_wr_data),
      .rd_addr    (ram_rd_addr)
   );

   payload_ram payload_ram_inst (
      .axi_aclk (axi_aclk),
      .wr_en    (ram_wr_en),
      .wr_addr  (ram_wr_addr),
      .wr_data  (ram_wr_data),
      .rd_addr  (ram_rd_addr),
      .rd_data  (ram_rd_data)
   );

endmodule

/* tests/tb_ualink_turbo64.sv */
/*
 * testbench for the ualink turbo64 endpoint
 * sends a table of packets, the checker module compares the output stream
 */
`timescale 1ns/100ps

module tb_ualink_turbo64
   import ualink_pkg::*;
();

   localparam int n_tests    = 10;
   localparam int wait_limit = 300; // cycles allowed for any single wait
   localparam int hold_len   = 20;

   // packet table, back-pressure 0 = ready, 1 = random ready, 2 = ready held low
   string     tab_name [n_tests] = '{"pass_fwd", "write_a40", "read_a40", "write_a252",
                                     "read_a252", "write_bp", "read_bp", "hold_stall",
                                     "read_short", "read_after"};
   int        tab_len  [n_tests] = '{14, 12, 12, 12, 13, 12, 14, 20, 7, 12};
   opcode_t   tab_op   [n_tests] = '{16'h0800, op_write, op_read, op_write, op_read,
                                     op_write, op_read, 16'h0800, op_read, op_read};
   ram_addr_t tab_addr [n_tests] = '{8'd16, 8'd40, 8'd40, 8'd252, 8'd252,
                                     8'd100, 8'd100, 8'd0, 8'd40, 8'd100};
   int        tab_seed [n_tests] = '{11, 23, 37, 41, 53, 67, 71, 83, 97, 101};
   int        tab_bp   [n_tests] = '{0, 0, 0, 0, 0, 1, 1, 2, 0, 1};

   logic         axi_aclk = 1'b0;
   logic         axi_resetn;
   word_t        s_axis_tdata;
   strb_t        s_axis_tstrb;
   user_t        s_axis_tuser;
   logic         s_axis_tvalid;
   logic         s_axis_tready;
   logic         s_axis_tlast;
   word_t        m_axis_tdata;
   strb_t        m_axis_tstrb;
   user_t        m_axis_tuser;
   logic         m_axis_tvalid;
   logic         m_axis_tready = 1'b1;
   logic         m_axis_tlast;
   logic [127:0] cur_name;
   logic         summary;
   int           pending;
   int           pass_count;
   int           fail_count;
   int           tb_errors  = 0;
   int           cycle_cnt  = 0;
   int           hold_until = 0;  // m_axis_tready low until this cycle
   logic         rand_ready = 1'b0;
   bit           aborted    = 1'b0;

   ualink_turbo64 #(.fifo_depth_bits(4)) ualink_turbo64_inst (.*);

   ualink_checker ualink_checker_inst (.test_name(cur_name), .*);

   always #4 axi_aclk = ~axi_aclk;

   // output side ready, hold and random mode sampled at the edge
   always @(posedge axi_aclk) begin
      logic rdy;
      cycle_cnt = cycle_cnt + 1;
      rdy = 1'b1;
      if (cycle_cnt < hold_until)
         rdy = 1'b0;
      else if (rand_ready)
         rdy = ($urandom_range(3, 0) != 0); // ready about 3 cycles in 4
      #1 m_axis_tready = rdy;
   end

   function automatic logic [127:0] pack_name(input string s);
      logic [127:0] bits;
      bits = '0;
      for (int i = 0; i < s.len() && i < 16; i++)
         bits[(s.len() - 1 - i) * 8 +: 8] = s[i];
      return bits;
   endfunction

   function automatic word_t beat_word(input int seed, input int beat, input opcode_t op,
                                       input ram_addr_t addr);
      word_t w;
      w = {seed[15:0], beat[7:0], 8'h5a, seed[15:0] ^ 16'h3c96, beat[7:0] ^ 8'hc3, seed[7:0]};
      if (beat == int'(opcode_beat))
         w[63:48] = op;
      if (beat == int'(addr_beat))
         w[63:56] = addr;
      return w;
   endfunction

   task automatic wait_cycle();
      @(posedge axi_aclk);
      #1;
   endtask

   task automatic send_packet(input int idx);
      int waited;
      int accepted;
      int low_at;
      accepted   = 0;
      low_at     = -1;             // beats accepted when ready first fell
      cur_name   = pack_name(tab_name[idx]);
      rand_ready = (tab_bp[idx] == 1);
      if (tab_bp[idx] == 2)
         hold_until = cycle_cnt + hold_len;
      for (int b = 0; b < tab_len[idx]; b++) begin
         s_axis_tdata  = beat_word(tab_seed[idx], b, tab_op[idx], tab_addr[idx]);
         s_axis_tstrb  = strb_t'($urandom());
         s_axis_tuser  = $urandom();
         s_axis_tlast  = (b == tab_len[idx] - 1);
         s_axis_tvalid = 1'b1;
         waited = 0;
         while (!s_axis_tready && waited < wait_limit) begin
            if (low_at < 0)
               low_at = accepted;
            wait_cycle();
            waited++;
         end
         if (!s_axis_tready) begin
            $display("%s: timed out waiting for s_axis_tready", tab_name[idx]);
            s_axis_tvalid = 1'b0;
            tb_errors++;
            aborted = 1'b1;
            return;
         end
         wait_cycle();             // beat taken at this edge
         accepted++;
      end
      s_axis_tvalid = 1'b0;
      s_axis_tlast  = 1'b0;
      if (tab_bp[idx] == 2 && (low_at < 0 || low_at >= 16)) begin
         $display("%s: s_axis_tready did not fall before 16 beats were taken", tab_name[idx]);
         tb_errors++;
      end
      waited = 0;
      while ((pending != 0 || m_axis_tvalid) && waited < wait_limit) begin
         wait_cycle();
         waited++;
      end
      if (pending != 0 || m_axis_tvalid) begin
         $display("%s: timed out waiting for the packet to drain", tab_name[idx]);
         tb_errors++;
         aborted = 1'b1;
      end
      rand_ready = 1'b0;
   endtask

   initial begin
      void'($urandom(93437));
      axi_resetn    = 1'b0;
      s_axis_tdata  = '0;
      s_axis_tstrb  = '0;
      s_axis_tuser  = '0;
      s_axis_tvalid = 1'b0;
      s_axis_tlast  = 1'b0;
      cur_name      = '0;
      summary       = 1'b0;
      repeat (16) @(posedge axi_aclk);
      #1 axi_resetn = 1'b1;
      if (m_axis_tvalid !== 1'b0 || s_axis_tready !== 1'b1) begin
         $display("Fail after_reset: valid/ready expected 01 actual %b%b",
                  m_axis_tvalid, s_axis_tready);
         tb_errors++;
      end else begin
         $display("pass after_reset");
      end
      for (int i = 0; i < n_tests; i++) begin
         send_packet(i);
         if (aborted)
            break;
      end
      summary = 1'b1;
      wait_cycle();
      if (!aborted && tb_errors == 0 && fail_count == 0 && pass_count == n_tests)
         $display("SIMULATION PASSED");
      else
         $display("SIMULATION FAILED");
      $finish;
   end

endmodule

/* tests/ualink_checker.sv */
/*
 * ualink stream checker
 * reference model of the command rules, compares every popped output beat
 */
`timescale 1ns/100ps

module ualink_checker
   import ualink_pkg::*;
(
   input  logic         axi_aclk,
   input  logic         axi_resetn,
   input  word_t        s_axis_tdata,
   input  strb_t        s_axis_tstrb,
   input  user_t        s_axis_tuser,
   input  logic         s_axis_tvalid,
   input  logic         s_axis_tready,
   input  logic         s_axis_tlast,
   input  word_t        m_axis_tdata,
   input  strb_t        m_axis_tstrb,
   input  user_t        m_axis_tuser,
   input  logic         m_axis_tvalid,
   input  logic         m_axis_tready,
   input  logic         m_axis_tlast,
   input  logic [127:0] test_name,
   input  logic         summary,
   output int           pending,
   output int           pass_count,
   output int           fail_count
);

   word_t        in_data_q [$];   // accepted input beats, oldest first
   strb_t        in_strb_q [$];
   user_t        in_user_q [$];
   logic         in_last_q [$];
   logic [127:0] name_q    [$];   // one entry per packet
   word_t        ref_mem   [256];

   logic      in_first;           // next input beat opens a packet
   int        out_beat;
   cmd_mode_t out_mode;
   ram_addr_t out_base;
   string     bad_msg;            // first mismatch in the packet
   int        passes = 0;
   int        fails  = 0;
   int        queued = 0;

   assign pending    = queued;
   assign pass_count = passes;
   assign fail_count = fails;

   function automatic string name_text(input logic [127:0] raw);
      string s;
      s = "";
      for (int i = 15; i >= 0; i--) begin
         if (raw[i*8 +: 8] != 8'd0)
            s = {s, $sformatf("%c", raw[i*8 +: 8])};
      end
      return s;
   endfunction

   task automatic note(input string field, input logic [63:0] exp, input logic [63:0] act);
      if (bad_msg == "")
         bad_msg = $sformatf("beat %0d %s expected %h actual %h", out_beat, field, exp, act);
   endtask

   task automatic check_beat();
      word_t     exp_data;
      strb_t     exp_strb;
      user_t     exp_user;
      logic      exp_last;
      ram_addr_t idx;
      string     name;
      if (in_data_q.size() == 0) begin
         $display("output beat seen with no input beat left to match it");
         fails++;
         return;
      end
      exp_data = in_data_q.pop_front();
      exp_strb = in_strb_q.pop_front();
      exp_user = in_user_q.pop_front();
      exp_last = in_last_q.pop_front();
      if (out_beat == int'(opcode_beat)) begin
         case (exp_data[63:48])
            op_write: out_mode = mode_write;
            op_read:  out_mode = mode_read;
            default:  out_mode = mode_pass;
         endcase
      end
      if (out_beat == int'(addr_beat))
         out_base = exp_data[63:56];
      if (out_beat >= int'(first_data_beat) && out_beat < int'(first_data_beat) + data_beats) begin
         idx = out_base + ram_addr_t'(out_beat - int'(first_data_beat)); // wraps at 255
         if (out_mode == mode_write)
            ref_mem[idx] = exp_data;
         else if (out_mode == mode_read)
            exp_data = ref_mem[idx];
      end
      if (m_axis_tdata !== exp_data) note("tdata", exp_data, m_axis_tdata);
      if (m_axis_tstrb !== exp_strb) note("tstrb", 64'(exp_strb), 64'(m_axis_tstrb));
      if (m_axis_tuser !== exp_user) note("tuser", 64'(exp_user), 64'(m_axis_tuser));
      if (m_axis_tlast !== exp_last) note("tlast", 64'(exp_last), 64'(m_axis_tlast));
      if (!exp_last) begin
         out_beat++;
         return;
      end
      name = "unnamed";
      if (name_q.size() != 0)
         name = name_text(name_q.pop_front());
      if (bad_msg != "") begin
         $display("Fail %s: %s", name, bad_msg);
         fails++;
      end else begin
         $display("pass %s: %0d beats", name, out_beat + 1);
         passes++;
      end
      out_beat = 0;
      out_mode = mode_pass;
      bad_msg  = "";
   endtask

   always @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         in_data_q.delete();
         in_strb_q.delete();
         in_user_q.delete();
         in_last_q.delete();
         name_q.delete();
         in_first = 1'b1;
         out_beat = 0;
         out_mode = mode_pass;
         out_base = '0;
         bad_msg  = "";
      end else begin
         if (m_axis_tvalid && m_axis_tready)
            check_beat();
         if (s_axis_tvalid && s_axis_tready) begin
            in_data_q.push_back(s_axis_tdata);
            in_strb_q.push_back(s_axis_tstrb);
            in_user_q.push_back(s_axis_tuser);
            in_last_q.push_back(s_axis_tlast);
            if (in_first)
               name_q.push_back(test_name);
            in_first = s_axis_tlast;
         end
      end
      queued = in_data_q.size();
   end

   always @(posedge summary)
      $display("packets checked %0d, passed %0d, failed %0d", passes + fails, passes, fails);

endmodule
